//--- logic/riscPkg.sv
package riscPkg;

    localparam int XLEN         = 64;
    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 5;

    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLui    = 7'b0110111;

    localparam logic [2:0] f3AddSub = 3'b000;   // also addi
    localparam logic [2:0] f3Ld     = 3'b011;
    localparam logic [2:0] f3Sd     = 3'b011;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam logic [6:0] f7Sub = 7'b0100000;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0]             imm;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0]              immHi;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [4:0]              immLo;
        logic [6:0]              opcode;
    } sFmtT;

    typedef struct packed {
        logic                    imm12;
        logic [5:0]              imm10to5;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [3:0]              imm4to1;
        logic                    imm11;
        logic [6:0]              opcode;
    } bFmtT;

    typedef struct packed {
        logic [19:0]             imm;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } uFmtT;

    // one fetched word, viewed per format
    typedef union packed {
        rFmtT r;
        iFmtT i;
        sFmtT s;
        bFmtT b;
        uFmtT u;
    } instrWordT;

    typedef enum logic [3:0] {
        opAdd, opSub, opAddi, opLoad, opStore, opBeq, opBne, opLui, opNone
    } opClassT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluPassB} aluOpT;
    typedef enum logic [1:0] {srcPc, srcFetchPc, srcRegA} srcASelT;
    typedef enum logic [1:0] {srcFour, srcImm, srcRegB} srcBSelT;

endpackage

//--- logic/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder import riscPkg::*; (
    input  instrWordT               instrReg,
    output opClassT                 opClass,
    output logic [regAddrWidth-1:0] rs1,
    output logic [regAddrWidth-1:0] rs2,
    output logic [regAddrWidth-1:0] rd,
    output logic [XLEN-1:0]         imm
);

    logic [6:0] opcode;

    assign opcode = instrReg.r.opcode;
    assign rs1    = instrReg.r.rs1;   // same position in every format that has it
    assign rs2    = instrReg.r.rs2;
    assign rd     = instrReg.r.rd;

    always_comb begin
        opClass = opNone;
        case (opcode)
            opcOp: begin
                if (instrReg.r.funct3 == f3AddSub) begin
                    if (instrReg.r.funct7 == 7'b0000000) opClass = opAdd;
                    else if (instrReg.r.funct7 == f7Sub) opClass = opSub;
                end
            end
            opcOpImm: if (instrReg.i.funct3 == f3AddSub) opClass = opAddi;
            opcLoad:  if (instrReg.i.funct3 == f3Ld) opClass = opLoad;
            opcStore: if (instrReg.s.funct3 == f3Sd) opClass = opStore;
            opcBranch: begin
                if (instrReg.b.funct3 == f3Beq) opClass = opBeq;
                else if (instrReg.b.funct3 == f3Bne) opClass = opBne;
            end
            opcLui:   opClass = opLui;
            default:  opClass = opNone;
        endcase
    end

    always_comb begin
        case (opcode)
            opcOpImm, opcLoad: imm = {{52{instrReg.i.imm[11]}}, instrReg.i.imm};
            opcStore: imm = {{52{instrReg.s.immHi[6]}}, instrReg.s.immHi, instrReg.s.immLo};
            opcBranch: begin
                imm = {{51{instrReg.b.imm12}}, instrReg.b.imm12, instrReg.b.imm11,
                       instrReg.b.imm10to5, instrReg.b.imm4to1, 1'b0};   // offset bit 0 is zero
            end
            opcLui:   imm = {{32{instrReg.u.imm[19]}}, instrReg.u.imm, 12'b0};
            default:  imm = '0;
        endcase
    end

endmodule

//--- logic/controlFsm.sv
`timescale 1ns/100ps

module controlFsm import riscPkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  opClassT opClass,
    input  logic    aluZero,
    input  logic    busDone,
    output logic    busReq,
    output logic    busWrite,
    output logic    busFetch,
    output logic    pcWrite,
    output logic    pcFromAlu,
    output logic    abWrite,
    output logic    aluOutWrite,
    output srcASelT srcASel,
    output srcBSelT srcBSel,
    output aluOpT   aluOp,
    output logic    regWrite,
    output logic    wbSelMem
);

    typedef enum logic [2:0] {
        stFetch, stDecode, stExecute, stBranch, stMemRead, stMemWrite, stWriteBack
    } stateT;

    stateT state;
    stateT nextState;
    logic  busBusy;   // request out, waiting for busDone

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            state   <= stFetch;
            busBusy <= 1'b0;
        end else begin
            state <= nextState;
            if (busDone) busBusy <= 1'b0;
            else if (busReq) busBusy <= 1'b1;
        end
    end

    always_comb begin
        nextState   = state;
        busReq      = 1'b0;
        busWrite    = 1'b0;
        busFetch    = 1'b0;
        pcWrite     = 1'b0;
        pcFromAlu   = 1'b0;
        abWrite     = 1'b0;
        aluOutWrite = 1'b0;
        srcASel     = srcPc;
        srcBSel     = srcImm;
        aluOp       = aluAdd;
        regWrite    = 1'b0;
        wbSelMem    = 1'b0;
        case (state)
            stFetch: begin
                busReq   = !busBusy;
                busFetch = 1'b1;
                srcBSel  = srcFour;   // pc + 4
                if (busDone) begin
                    pcWrite   = 1'b1;
                    nextState = stDecode;
                end
            end
            stDecode: begin
                abWrite     = 1'b1;
                aluOutWrite = 1'b1;
                srcASel     = srcFetchPc;   // branch target into aluOut
                case (opClass)
                    opBeq, opBne: nextState = stBranch;
                    opNone:       nextState = stFetch;
                    default:      nextState = stExecute;
                endcase
            end
            stExecute: begin
                aluOutWrite = 1'b1;
                srcASel     = srcRegA;
                if (opClass == opAdd || opClass == opSub) srcBSel = srcRegB;
                if (opClass == opSub) aluOp = aluSub;
                if (opClass == opLui) aluOp = aluPassB;
                if (opClass == opLoad) nextState = stMemRead;
                else if (opClass == opStore) nextState = stMemWrite;
                else nextState = stWriteBack;
            end
            stBranch: begin
                srcASel = srcRegA;
                srcBSel = srcRegB;
                aluOp   = aluSub;
                if ((opClass == opBeq && aluZero) || (opClass == opBne && !aluZero)) begin
                    pcWrite   = 1'b1;
                    pcFromAlu = 1'b1;
                end
                nextState = stFetch;
            end
            stMemRead: begin
                busReq = !busBusy;
                if (busDone) nextState = stWriteBack;
            end
            stMemWrite: begin
                busReq   = !busBusy;
                busWrite = 1'b1;
                if (busDone) nextState = stFetch;
            end
            stWriteBack: begin
                regWrite  = 1'b1;
                wbSelMem  = (opClass == opLoad);
                nextState = stFetch;
            end
            default: nextState = stFetch;
        endcase
    end

endmodule

//--- logic/busMaster.sv
`timescale 1ns/100ps

module busMaster import riscPkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic            busReq,
    input  logic            busWrite,
    input  logic            busFetch,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] aluOut,
    input  logic [XLEN-1:0] storeData,
    output logic            busDone,
    output instrWordT       instrReg,
    output logic [XLEN-1:0] mdr,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output logic [XLEN-1:0] wbAdr,
    output logic [XLEN-1:0] wbDatOut,
    input  logic [XLEN-1:0] wbDatIn,
    input  logic            wbAck
);

    logic cycActive;
    logic fetchCycle;
    logic startCycle;

    assign startCycle = busReq && !cycActive;
    assign wbCyc      = cycActive;
    assign wbStb      = cycActive;
    assign busDone    = cycActive && wbAck;

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            cycActive  <= 1'b0;
            wbWe       <= 1'b0;
            fetchCycle <= 1'b0;
        end else if (busDone) begin
            cycActive <= 1'b0;   // drop on the edge after ack
            wbWe      <= 1'b0;
        end else if (startCycle) begin
            cycActive  <= 1'b1;
            wbWe       <= busWrite;
            fetchCycle <= busFetch;
        end
    end

    always_ff @(posedge CLK) begin
        if (startCycle) begin
            wbAdr    <= busFetch ? pc : aluOut;
            wbDatOut <= storeData;
        end
        if (busDone && fetchCycle) begin
            instrReg <= wbAdr[2] ? wbDatIn[XLEN-1:instrWidth] : wbDatIn[instrWidth-1:0];
        end
        if (busDone && !fetchCycle && !wbWe) mdr <= wbDatIn;   // ld data
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps

module regFile import riscPkg::*; (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] rd,
    input  logic                    regWrite,
    input  logic [XLEN-1:0]         writeData,
    output logic [XLEN-1:0]         rdata1,
    output logic [XLEN-1:0]         rdata2
);

    logic [XLEN-1:0] regs [2**regAddrWidth];

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin   // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/100ps

module executeUnit import riscPkg::*; #(
    parameter logic [XLEN-1:0] resetPc = '0
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    input  logic [XLEN-1:0] mdr,
    input  logic            wbSelMem,
    input  logic            pcWrite,
    input  logic            pcFromAlu,
    input  logic            abWrite,
    input  logic            aluOutWrite,
    input  srcASelT         srcASel,
    input  srcBSelT         srcBSel,
    input  aluOpT           aluOp,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] aluOut,
    output logic [XLEN-1:0] storeData,
    output logic [XLEN-1:0] writeData,
    output logic            aluZero
);

    logic [XLEN-1:0] fetchPc;
    logic [XLEN-1:0] regA;
    logic [XLEN-1:0] regB;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;

    always_comb begin
        case (srcASel)
            srcPc:      opA = pc;
            srcFetchPc: opA = fetchPc;
            default:    opA = regA;
        endcase
        case (srcBSel)
            srcFour: opB = XLEN'(4);
            srcImm:  opB = imm;
            default: opB = regB;
        endcase
        case (aluOp)
            aluSub:   aluResult = opA - opB;
            aluPassB: aluResult = opB;   // lui
            default:  aluResult = opA + opB;
        endcase
    end

    assign aluZero   = (aluResult == '0);
    assign storeData = regB;
    assign writeData = wbSelMem ? mdr : aluOut;

    // the only non-aluOut pc write is pc + 4 at fetch, so fetchPc follows it
    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            pc      <= resetPc;
            fetchPc <= resetPc;
        end else if (pcWrite) begin
            pc <= pcFromAlu ? aluOut : aluResult;
            if (!pcFromAlu) fetchPc <= pc;
        end
    end

    always_ff @(posedge CLK) begin
        if (abWrite) begin
            regA <= rdata1;
            regB <= rdata2;
        end
        if (aluOutWrite) aluOut <= aluResult;
    end

endmodule

//--- logic/riscCore.sv
`timescale 1ns/100ps

module riscCore import riscPkg::*; #(
    parameter logic [XLEN-1:0] resetPc = '0
) (
    input  logic            CLK,
    input  logic            RST,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output logic [XLEN-1:0] wbAdr,
    output logic [XLEN-1:0] wbDatOut,
    input  logic [XLEN-1:0] wbDatIn,
    input  logic            wbAck
);

    logic                    busReq;
    logic                    busWrite;
    logic                    busFetch;
    logic                    busDone;
    instrWordT               instrReg;
    logic [XLEN-1:0]         mdr;
    opClassT                 opClass;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    logic [XLEN-1:0]         imm;
    logic                    pcWrite;
    logic                    pcFromAlu;
    logic                    abWrite;
    logic                    aluOutWrite;
    srcASelT                 srcASel;
    srcBSelT                 srcBSel;
    aluOpT                   aluOp;
    logic                    aluZero;
    logic                    regWrite;
    logic                    wbSelMem;
    logic [XLEN-1:0]         rdata1;
    logic [XLEN-1:0]         rdata2;
    logic [XLEN-1:0]         writeData;
    logic [XLEN-1:0]         storeData;
    logic [XLEN-1:0]         pc;
    logic [XLEN-1:0]         aluOut;

    busMaster i_busMaster (
        .CLK, .RST, .busReq, .busWrite, .busFetch, .pc, .aluOut, .storeData,
        .busDone, .instrReg, .mdr,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut, .wbDatIn, .wbAck
    );

    instrDecoder i_instrDecoder (
        .instrReg, .opClass, .rs1, .rs2, .rd, .imm
    );

    controlFsm i_controlFsm (
        .CLK, .RST, .opClass, .aluZero, .busDone,
        .busReq, .busWrite, .busFetch,
        .pcWrite, .pcFromAlu, .abWrite, .aluOutWrite,
        .srcASel, .srcBSel, .aluOp, .regWrite, .wbSelMem
    );

    regFile i_regFile (
        .CLK, .RST, .rs1, .rs2, .rd, .regWrite, .writeData, .rdata1, .rdata2
    );

    executeUnit #(.resetPc(resetPc)) i_executeUnit (
        .CLK, .RST, .imm, .rdata1, .rdata2, .mdr, .wbSelMem,
        .pcWrite, .pcFromAlu, .abWrite, .aluOutWrite,
        .srcASel, .srcBSel, .aluOp,
        .pc, .aluOut, .storeData, .writeData, .aluZero
    );

endmodule

//--- tb/riscCore_assertions.sv
`timescale 1ns/100ps

module riscCoreAssertions import riscPkg::*; (
    input logic            CLK,
    input logic            RST,
    input logic            wbCyc,
    input logic            wbStb,
    input logic            wbWe,
    input logic            wbAck,
    input logic [XLEN-1:0] wbAdr,
    input logic [XLEN-1:0] wbDatOut
);

    stbNeedsCyc: assert property (@(posedge CLK) disable iff (RST) wbStb |-> wbCyc)
        else $error("wishbone stb high without cyc");

    // master must hold the request until the slave answers
    heldUntilAck: assert property (@(posedge CLK) disable iff (RST)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut))
        else $error("wishbone request changed or dropped before ack");

    dropAfterAck: assert property (@(posedge CLK) disable iff (RST)
        wbCyc && wbAck |=> !wbCyc && !wbStb)
        else $error("wishbone cyc or stb still high after ack");

endmodule

//--- tb/riscCoreTb.sv
`timescale 1ns/100ps

module riscCoreTb import riscPkg::*; ;

    localparam int numInstr   = 300;
    localparam int progBytes  = numInstr * 4;
    localparam int memWords   = 512;    // 4 KiB, only adr[11:3] decoded
    localparam int dataBase   = 'h100;  // word index of 0x800
    localparam int ackTimeout = 200;
    localparam logic [XLEN-1:0] tbResetPc = '0;

    logic            CLK;
    logic            RST;
    logic            wbCyc;
    logic            wbStb;
    logic            wbWe;
    logic            wbAck;
    logic [XLEN-1:0] wbAdr;
    logic [XLEN-1:0] wbDatOut;
    logic [XLEN-1:0] wbDatIn;

    logic [31:0]     prog [numInstr];
    opClassT         kind [numInstr];
    logic [4:0]      rdF [numInstr];
    logic [4:0]      rs1F [numInstr];
    logic [4:0]      rs2F [numInstr];
    logic [XLEN-1:0] immF [numInstr];
    logic [XLEN-1:0] busMem [memWords];
    logic [XLEN-1:0] modelMem [memWords];
    logic [XLEN-1:0] modelRegs [32];
    logic [XLEN-1:0] modelPc;
    int              seed = 32'h17aa4771;
    int              storeCount = 0;
    int              modelStores;

    riscCore #(.resetPc(tbResetPc)) i_riscCore (
        .CLK, .RST, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut, .wbDatIn, .wbAck
    );

    bind riscCore riscCoreAssertions i_riscCoreAssertions (
        .CLK(CLK), .RST(RST), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAck(wbAck), .wbAdr(wbAdr), .wbDatOut(wbDatOut)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // write cycles the core completes on the bus
    always @(posedge CLK) begin
        if (wbCyc && wbStb && wbWe && wbAck) storeCount <= storeCount + 1;
    end

    function automatic int randBelow(int unsigned n);
        int unsigned r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic void writeReg(logic [4:0] rd, logic [XLEN-1:0] value);
        if (rd != 5'd0) modelRegs[rd] = value;   // x0 is hardwired
    endfunction

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic makeProgram();
        int          pick;
        int          off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        for (int i = 0; i < numInstr; i++) begin
            pick  = randBelow(8);
            rd    = 5'(randBelow(32));
            rs1   = 5'(1 + randBelow(31));
            rs2   = 5'(1 + randBelow(31));
            off   = 'h800 + 8 * randBelow(256);
            imm12 = 12'(off);   // above 0x7ff this sign-extends, memory aliases it
            case (pick)
                0: begin
                    kind[i] = opAdd;
                    prog[i] = {7'b0000000, rs2, rs1, f3AddSub, rd, opcOp};
                end
                1: begin
                    kind[i] = opSub;
                    prog[i] = {f7Sub, rs2, rs1, f3AddSub, rd, opcOp};
                end
                2: begin
                    kind[i] = opAddi;
                    imm12   = 12'(randBelow(4096));
                    prog[i] = {imm12, rs1, f3AddSub, rd, opcOpImm};
                end
                3: begin
                    kind[i] = opLoad;
                    rs1     = 5'd0;
                    prog[i] = {imm12, rs1, f3Ld, rd, opcLoad};
                end
                4: begin
                    kind[i] = opStore;
                    rs1     = 5'd0;
                    prog[i] = {imm12[11:5], rs2, rs1, f3Sd, imm12[4:0], opcStore};
                end
                5, 6: begin
                    kind[i] = (pick == 5) ? opBeq : opBne;
                    if (randBelow(4) == 0) rs2 = rs1;   // more equal operands
                    imm13 = 13'(4 * (1 + randBelow(16)));
                    prog[i] = {imm13[12], imm13[10:5], rs2, rs1, (pick == 5) ? f3Beq : f3Bne,
                               imm13[4:1], imm13[11], opcBranch};
                end
                default: begin
                    kind[i] = opLui;
                    imm20   = 20'(randBelow(32'hfffff) + 1);
                    prog[i] = {imm20, rd, opcLui};
                end
            endcase
            rdF[i]  = rd;
            rs1F[i] = rs1;
            rs2F[i] = rs2;
            if (kind[i] == opLui) immF[i] = {{32{imm20[19]}}, imm20, 12'b0};
            else if (pick == 5 || pick == 6) immF[i] = {{51{imm13[12]}}, imm13};
            else if (pick >= 2) immF[i] = {{52{imm12[11]}}, imm12};
            else immF[i] = '0;
        end
    endtask

    task automatic fillMemory();
        for (int w = 0; w < memWords; w++) begin
            if (w >= dataBase) busMem[w] = {$random(seed), $random(seed)};
            else busMem[w] = '0;
        end
        for (int i = 0; i < numInstr; i++) begin
            busMem[i / 2][32 * (i % 2) +: 32] = prog[i];   // odd slot is the high half
        end
        modelMem = busMem;
    endtask

    // waits for one bus cycle, adds 0 to 3 wait states, then acks it
    task automatic serveCycle(output logic [XLEN-1:0] adr, output logic we,
                              output logic [XLEN-1:0] dat);
        int waited;
        int waits;
        waited = 0;
        @(posedge CLK);
        while (!wbCyc) begin
            assert (!wbStb && !wbWe) else begin
                $display("Strobe or write enable was high outside a bus cycle");
                stopRun();
            end
            waited++;
            if (waited > ackTimeout) begin
                $display("Timeout, the core stopped responding and started no bus cycle");
                stopRun();
            end
            @(posedge CLK);
        end
        assert (wbStb) else begin
            $display("Strobe was low during a bus cycle");
            stopRun();
        end
        adr   = wbAdr;
        we    = wbWe;
        dat   = wbDatOut;
        waits = randBelow(4);
        for (int k = 0; k < waits; k++) @(posedge CLK);
        if (we) busMem[adr[11:3]] = dat;
        wbDatIn <= we ? '0 : busMem[adr[11:3]];
        wbAck   <= 1'b1;
        @(posedge CLK);
        wbAck   <= 1'b0;
        wbDatIn <= '0;
    endtask

    task automatic stepModel();
        int              idx;
        logic [XLEN-1:0] nextPc;
        logic [XLEN-1:0] va;
        logic [XLEN-1:0] vb;
        logic [XLEN-1:0] expAdr;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        logic            we;
        idx    = int'(modelPc[31:2]);
        nextPc = modelPc + 64'd4;
        va     = modelRegs[rs1F[idx]];
        vb     = modelRegs[rs2F[idx]];
        expAdr = va + immF[idx];
        case (kind[idx])
            opAdd:  writeReg(rdF[idx], va + vb);
            opSub:  writeReg(rdF[idx], va - vb);
            opAddi: writeReg(rdF[idx], expAdr);
            opLui:  writeReg(rdF[idx], immF[idx]);
            opLoad: begin
                serveCycle(adr, we, dat);
                checkValue("ld write enable", '0, XLEN'(we));
                checkValue("ld address", expAdr, adr);
                writeReg(rdF[idx], modelMem[expAdr[11:3]]);
            end
            opStore: begin
                serveCycle(adr, we, dat);
                checkValue("sd write enable", XLEN'(1), XLEN'(we));
                checkValue("sd address", expAdr, adr);
                checkValue("sd data", vb, dat);
                modelMem[expAdr[11:3]] = vb;
                modelStores++;
            end
            opBeq:  if (va == vb) nextPc = modelPc + immF[idx];
            opBne:  if (va != vb) nextPc = modelPc + immF[idx];
            default: ;
        endcase
        modelPc = nextPc;
    endtask

    initial begin
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        logic            we;
        logic            done;
        RST         = 1'b1;
        wbAck       = 1'b0;
        wbDatIn     = '0;
        modelStores = 0;
        makeProgram();
        fillMemory();
        for (int r = 0; r < 32; r++) modelRegs[r] = '0;
        modelPc = tbResetPc;
        for (int c = 0; c < 4; c++) begin
            @(posedge CLK);
            assert (!wbCyc && !wbStb && !wbWe) else begin
                $display("Bus was active while reset was asserted");
                stopRun();
            end
        end
        RST  <= 1'b0;
        done = 1'b0;
        while (!done) begin
            serveCycle(adr, we, dat);
            checkValue("fetch write enable", '0, XLEN'(we));
            checkValue("fetch address", modelPc, adr);
            if (modelPc >= XLEN'(progBytes)) done = 1'b1;   // fetched past the program
            else stepModel();
        end
        checkValue("retired stores", XLEN'(modelStores), XLEN'(storeCount));
        $display("All checks passed");
        $finish;
    end

endmodule

//--- riscCore.f
logic/riscPkg.sv
logic/instrDecoder.sv
logic/controlFsm.sv
logic/busMaster.sv
logic/regFile.sv
logic/executeUnit.sv
logic/riscCore.sv
tb/riscCore_assertions.sv
tb/riscCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the riscCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module riscCoreTb -f riscCore.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VriscCoreTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1
